// ==== source/ntt_ctrl_pkg.sv ====
`default_nettype none

package ntt_ctrl_pkg;

    // shared widths and counts
    localparam int DEPTH_W = 8;

    localparam logic [DEPTH_W-1:0] DEGREE          = DEPTH_W'(16);
    localparam logic [DEPTH_W-1:0] ISSUE_TOTAL     = DEPTH_W'(8);
    localparam logic [DEPTH_W-1:0] ISSUE_TOTAL_K2  = DEPTH_W'(4);
    localparam logic [DEPTH_W-1:0] AGU_ITE0_CYCLES = DEPTH_W'(6);

    // drain lengths are bound + 1 cycles
    localparam logic [DEPTH_W-1:0] DRAIN0_BOUND = DEPTH_W'(12);
    localparam logic [DEPTH_W-1:0] DRAIN1_BOUND = DEPTH_W'(12);
    localparam logic [DEPTH_W-1:0] DRAIN2_BOUND = DEPTH_W'(12);
    localparam logic [DEPTH_W-1:0] DRAIN3_BOUND = DEPTH_W'(2);

    localparam logic [DEPTH_W-1:0] LAST_L          = DEPTH_W'(5);
    localparam logic [DEPTH_W-1:0] ITE2_BASE_DEPTH = DEPTH_W'(2);

    typedef enum logic [3:0] {
        RESET_PH,
        IDLE,
        ITE0,
        DRAIN0,
        ITE1,
        DRAIN1,
        ITE2,
        DRAIN2,
        ITE3,
        DRAIN3,
        FINISH
    } phase_e;

    typedef enum logic [2:0] {
        DRAIN_NONE,
        DRAIN_0,
        DRAIN_1,
        DRAIN_2,
        DRAIN_3
    } drain_e;

    // true in any butterfly iteration phase
    function automatic logic is_ite_phase(phase_e ph);
        return (ph == ITE0) || (ph == ITE1) || (ph == ITE2) || (ph == ITE3);
    endfunction

endpackage

`default_nettype wire

// ==== source/ntt_phase_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntt_phase_fsm (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  init_done,
    input  wire                  issue_last,
    input  wire                  drain_last,
    output ntt_ctrl_pkg::phase_e phase
);

    ntt_ctrl_pkg::phase_e phase_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= ntt_ctrl_pkg::RESET_PH;
        end else begin
            phase <= phase_next;
        end
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            // leave reset on the first edge after release
            ntt_ctrl_pkg::RESET_PH: begin
                phase_next = ntt_ctrl_pkg::IDLE;
            end
            ntt_ctrl_pkg::IDLE: begin
                if (init_done) begin
                    phase_next = ntt_ctrl_pkg::ITE0;
                end
            end
            ntt_ctrl_pkg::ITE0: begin
                if (issue_last) begin
                    phase_next = ntt_ctrl_pkg::DRAIN0;
                end
            end
            ntt_ctrl_pkg::DRAIN0: begin
                if (drain_last) begin
                    phase_next = ntt_ctrl_pkg::ITE1;
                end
            end
            ntt_ctrl_pkg::ITE1: begin
                if (issue_last) begin
                    phase_next = ntt_ctrl_pkg::DRAIN1;
                end
            end
            ntt_ctrl_pkg::DRAIN1: begin
                if (drain_last) begin
                    phase_next = ntt_ctrl_pkg::ITE2;
                end
            end
            ntt_ctrl_pkg::ITE2: begin
                if (issue_last) begin
                    phase_next = ntt_ctrl_pkg::DRAIN2;
                end
            end
            ntt_ctrl_pkg::DRAIN2: begin
                if (drain_last) begin
                    phase_next = ntt_ctrl_pkg::ITE3;
                end
            end
            // radix-2 iteration
            ntt_ctrl_pkg::ITE3: begin
                if (issue_last) begin
                    phase_next = ntt_ctrl_pkg::DRAIN3;
                end
            end
            ntt_ctrl_pkg::DRAIN3: begin
                if (drain_last) begin
                    phase_next = ntt_ctrl_pkg::FINISH;
                end
            end
            ntt_ctrl_pkg::FINISH: begin
                phase_next = ntt_ctrl_pkg::IDLE;
            end
            default: begin
                phase_next = ntt_ctrl_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ntt_phase_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntt_phase_counters (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire ntt_ctrl_pkg::phase_e            phase,
    input  wire                                  tf_ren,
    output logic                                 init_done,
    output logic                                 issue_last,
    output logic                                 drain_last,
    output logic                                 agu_ite0_active,
    output logic [ntt_ctrl_pkg::DEPTH_W-1:0]     depth_pattern
);

    logic [ntt_ctrl_pkg::DEPTH_W-1:0] init_cnt;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] issue_cnt;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] issue_bound;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] drain_cnt;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] drain_bound;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] agu_cnt;
    logic [1:0]                       pattern_cnt;
    ntt_ctrl_pkg::drain_e             drain_sel;
    logic                             in_ite;

    assign in_ite = ntt_ctrl_pkg::is_ite_phase(phase);

    // init wait, sticky once reached
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (init_cnt == ntt_ctrl_pkg::DEGREE) begin
                init_done <= 1'b1;
            end
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // radix-2 iteration has fewer issues
    assign issue_bound = (phase == ntt_ctrl_pkg::ITE3) ? ntt_ctrl_pkg::ISSUE_TOTAL_K2
                                                       : ntt_ctrl_pkg::ISSUE_TOTAL;

    assign issue_last = in_ite && tf_ren && (issue_cnt == issue_bound - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_cnt <= '0;
        end else if (!in_ite || issue_last) begin
            issue_cnt <= '0;
        end else if (tf_ren) begin
            issue_cnt <= issue_cnt + 1'b1;
        end
    end

    always_comb begin
        case (phase)
            ntt_ctrl_pkg::DRAIN0: drain_sel = ntt_ctrl_pkg::DRAIN_0;
            ntt_ctrl_pkg::DRAIN1: drain_sel = ntt_ctrl_pkg::DRAIN_1;
            ntt_ctrl_pkg::DRAIN2: drain_sel = ntt_ctrl_pkg::DRAIN_2;
            ntt_ctrl_pkg::DRAIN3: drain_sel = ntt_ctrl_pkg::DRAIN_3;
            default:              drain_sel = ntt_ctrl_pkg::DRAIN_NONE;
        endcase
    end

    always_comb begin
        case (drain_sel)
            ntt_ctrl_pkg::DRAIN_0: drain_bound = ntt_ctrl_pkg::DRAIN0_BOUND;
            ntt_ctrl_pkg::DRAIN_1: drain_bound = ntt_ctrl_pkg::DRAIN1_BOUND;
            ntt_ctrl_pkg::DRAIN_2: drain_bound = ntt_ctrl_pkg::DRAIN2_BOUND;
            ntt_ctrl_pkg::DRAIN_3: drain_bound = ntt_ctrl_pkg::DRAIN3_BOUND;
            default:               drain_bound = '0;
        endcase
    end

    // counts 0..bound, so bound+1 cycles
    assign drain_last = (drain_sel != ntt_ctrl_pkg::DRAIN_NONE) && (drain_cnt == drain_bound);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_cnt <= '0;
        end else if ((drain_sel == ntt_ctrl_pkg::DRAIN_NONE) || drain_last) begin
            drain_cnt <= '0;
        end else begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    // radix-4 agu only runs for the first cycles of ite0
    assign agu_ite0_active = (phase == ntt_ctrl_pkg::ITE0) &&
                             (agu_cnt < ntt_ctrl_pkg::AGU_ITE0_CYCLES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            agu_cnt <= '0;
        end else if (phase != ntt_ctrl_pkg::ITE0) begin
            agu_cnt <= '0;
        end else if (agu_cnt != ntt_ctrl_pkg::AGU_ITE0_CYCLES) begin
            agu_cnt <= agu_cnt + 1'b1;
        end
    end

    // ite2 depth walks base, base+1, base+1, base
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern_cnt <= '0;
        end else if (phase != ntt_ctrl_pkg::ITE2) begin
            pattern_cnt <= '0;
        end else if (tf_ren) begin
            pattern_cnt <= pattern_cnt + 1'b1;
        end
    end

    assign depth_pattern = ((pattern_cnt == 2'd1) || (pattern_cnt == 2'd2))
                         ? ntt_ctrl_pkg::ITE2_BASE_DEPTH + 1'b1
                         : ntt_ctrl_pkg::ITE2_BASE_DEPTH;

endmodule

`default_nettype wire

// ==== source/ntt_ctrl_outputs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_outputs (
    input  wire ntt_ctrl_pkg::phase_e            phase,
    input  wire                                  bn_ma_out_en,
    input  wire                                  r_enable_out,
    input  wire [1:0]                            ntt_done,
    input  wire                                  agu_ite0_active,
    input  wire [ntt_ctrl_pkg::DEPTH_W-1:0]      depth_pattern,
    output logic                                 tf_init_base,
    output logic                                 tf_ren,
    output logic [ntt_ctrl_pkg::DEPTH_W-1:0]     it_depth_cnt,
    output logic                                 agu_enable,
    output logic                                 agu_enable_k2,
    output logic                                 r_enable,
    output logic                                 w_enable,
    output logic                                 last_stage,
    output logic                                 ntt_enable,
    output logic                                 done
);

    logic in_ite;
    logic in_drain;
    logic issue;
    logic busy;

    assign in_ite   = ntt_ctrl_pkg::is_ite_phase(phase);
    assign in_drain = (phase == ntt_ctrl_pkg::DRAIN0) || (phase == ntt_ctrl_pkg::DRAIN1) ||
                      (phase == ntt_ctrl_pkg::DRAIN2) || (phase == ntt_ctrl_pkg::DRAIN3);
    assign busy     = in_ite || in_drain;

    // issue whenever upstream data is ready
    assign issue = in_ite && bn_ma_out_en;

    assign tf_init_base = (phase == ntt_ctrl_pkg::IDLE);
    assign tf_ren       = issue;
    assign r_enable     = issue;

    always_comb begin
        it_depth_cnt = '0;
        if (issue) begin
            case (phase)
                ntt_ctrl_pkg::ITE1: it_depth_cnt = ntt_ctrl_pkg::DEPTH_W'(1);
                ntt_ctrl_pkg::ITE2: it_depth_cnt = depth_pattern;
                ntt_ctrl_pkg::ITE3: it_depth_cnt = ntt_ctrl_pkg::LAST_L;
                default:            it_depth_cnt = '0;
            endcase
        end
    end

    // writes follow butterfly results, drains flush
    always_comb begin
        if (in_drain) begin
            w_enable = 1'b1;
        end else if (in_ite) begin
            w_enable = |ntt_done;
        end else begin
            w_enable = 1'b0;
        end
    end

    assign ntt_enable = busy && r_enable_out;

    always_comb begin
        case (phase)
            ntt_ctrl_pkg::ITE0: agu_enable = agu_ite0_active;
            ntt_ctrl_pkg::ITE1: agu_enable = 1'b1;
            ntt_ctrl_pkg::ITE2: agu_enable = 1'b1;
            default:            agu_enable = 1'b0;
        endcase
    end

    assign agu_enable_k2 = (phase == ntt_ctrl_pkg::ITE3);
    assign last_stage    = (phase == ntt_ctrl_pkg::ITE3) || (phase == ntt_ctrl_pkg::DRAIN3);
    assign done          = (phase == ntt_ctrl_pkg::FINISH);

endmodule

`default_nettype wire

// ==== source/ntt_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_top (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  bn_ma_out_en,
    input  wire                                  r_enable_out,
    input  wire [1:0]                            ntt_done,
    output logic                                 tf_init_base,
    output logic                                 tf_ren,
    output logic [ntt_ctrl_pkg::DEPTH_W-1:0]     it_depth_cnt,
    output logic                                 agu_enable,
    output logic                                 agu_enable_k2,
    output logic                                 r_enable,
    output logic                                 w_enable,
    output logic                                 last_stage,
    output logic                                 ntt_enable,
    output logic                                 done
);

    ntt_ctrl_pkg::phase_e             phase;
    logic                             init_done;
    logic                             issue_last;
    logic                             drain_last;
    logic                             agu_ite0_active;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] depth_pattern;

    ntt_phase_fsm ntt_phase_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .init_done  (init_done),
        .issue_last (issue_last),
        .drain_last (drain_last),
        .phase      (phase)
    );

    // tf_ren doubles as the issue strobe
    ntt_phase_counters ntt_phase_counters_inst (
        .clk             (clk),
        .rst             (rst),
        .phase           (phase),
        .tf_ren          (tf_ren),
        .init_done       (init_done),
        .issue_last      (issue_last),
        .drain_last      (drain_last),
        .agu_ite0_active (agu_ite0_active),
        .depth_pattern   (depth_pattern)
    );

    ntt_ctrl_outputs ntt_ctrl_outputs_inst (
        .phase           (phase),
        .bn_ma_out_en    (bn_ma_out_en),
        .r_enable_out    (r_enable_out),
        .ntt_done        (ntt_done),
        .agu_ite0_active (agu_ite0_active),
        .depth_pattern   (depth_pattern),
        .tf_init_base    (tf_init_base),
        .tf_ren          (tf_ren),
        .it_depth_cnt    (it_depth_cnt),
        .agu_enable      (agu_enable),
        .agu_enable_k2   (agu_enable_k2),
        .r_enable        (r_enable),
        .w_enable        (w_enable),
        .last_stage      (last_stage),
        .ntt_enable      (ntt_enable),
        .done            (done)
    );

endmodule

`default_nettype wire

// ==== tests/ntt_ctrl_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_assertions (
    input wire clk,
    input wire rst,
    input wire done,
    input wire tf_ren,
    input wire r_enable,
    input wire agu_enable,
    input wire agu_enable_k2
);

    int failures = 0;

    // done is a one cycle pulse
    property done_one_cycle;
        @(posedge clk) disable iff (rst)
        done |=> !done;
    endproperty

    property read_with_twiddle;
        @(posedge clk) disable iff (rst)
        r_enable |-> tf_ren;
    endproperty

    // radix-4 and radix-2 address modes never overlap
    property agu_modes_exclusive;
        @(posedge clk) disable iff (rst)
        !(agu_enable && agu_enable_k2);
    endproperty

    done_pulse_check: assert property (done_one_cycle) else begin
        failures++;
        $error("done stayed high for two cycles");
    end

    read_twiddle_check: assert property (read_with_twiddle) else begin
        failures++;
        $error("memory read without twiddle read");
    end

    agu_mode_check: assert property (agu_modes_exclusive) else begin
        failures++;
        $error("both address generator modes enabled");
    end

endmodule

bind ntt_ctrl_top ntt_ctrl_assertions ntt_ctrl_assertions_inst (
    .clk           (clk),
    .rst           (rst),
    .done          (done),
    .tf_ren        (tf_ren),
    .r_enable      (r_enable),
    .agu_enable    (agu_enable),
    .agu_enable_k2 (agu_enable_k2)
);

`default_nettype wire

// ==== tests/ntt_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_tb;

    localparam int NUM_ROWS       = 5;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int ISSUES_PER_RUN = 3 * int'(ntt_ctrl_pkg::ISSUE_TOTAL)
                                  + int'(ntt_ctrl_pkg::ISSUE_TOTAL_K2);
    // every drain is bound + 1 cycles long
    localparam int DRAIN_WRITES   = int'(ntt_ctrl_pkg::DRAIN0_BOUND)
                                  + int'(ntt_ctrl_pkg::DRAIN1_BOUND)
                                  + int'(ntt_ctrl_pkg::DRAIN2_BOUND)
                                  + int'(ntt_ctrl_pkg::DRAIN3_BOUND)
                                  + 4;

    // reference model phases
    localparam int M_RESET  = 0;
    localparam int M_IDLE   = 1;
    localparam int M_ITE    = 2;
    localparam int M_DRAIN  = 3;
    localparam int M_FINISH = 4;

    logic                             clk;
    logic                             rst;
    logic                             bn_ma_out_en;
    logic                             r_enable_out;
    logic [1:0]                       ntt_done;
    logic                             tf_init_base;
    logic                             tf_ren;
    logic [ntt_ctrl_pkg::DEPTH_W-1:0] it_depth_cnt;
    logic                             agu_enable;
    logic                             agu_enable_k2;
    logic                             r_enable;
    logic                             w_enable;
    logic                             last_stage;
    logic                             ntt_enable;
    logic                             done;

    // stimulus table, one transform per row
    string row_name     [NUM_ROWS];
    int    row_bn_pct   [NUM_ROWS];
    int    row_ren_pct  [NUM_ROWS];
    int    row_done_pct [NUM_ROWS];
    int    row_issues   [NUM_ROWS];
    int    row_drain_w  [NUM_ROWS];

    logic [31:0] lcg_state;
    int          errors;
    int          cycles;
    int          m_ph;
    int          m_it;
    int          m_cnt;
    int          m_phc;
    int          m_init;
    int          n_ren;
    int          n_ren_tf;
    int          n_wdrain;
    int          n_base;
    logic        seen_done;

    ntt_ctrl_top ntt_ctrl_top_inst (
        .clk           (clk),
        .rst           (rst),
        .bn_ma_out_en  (bn_ma_out_en),
        .r_enable_out  (r_enable_out),
        .ntt_done      (ntt_done),
        .tf_init_base  (tf_init_base),
        .tf_ren        (tf_ren),
        .it_depth_cnt  (it_depth_cnt),
        .agu_enable    (agu_enable),
        .agu_enable_k2 (agu_enable_k2),
        .r_enable      (r_enable),
        .w_enable      (w_enable),
        .last_stage    (last_stage),
        .ntt_enable    (ntt_enable),
        .done          (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, lcg_state[31:16]};
    endfunction

    function automatic logic chance(input int pct);
        return (next_random() % 32'd100) < 32'(pct);
    endfunction

    function automatic int issue_target(input int it);
        return (it == 3) ? int'(ntt_ctrl_pkg::ISSUE_TOTAL_K2) : int'(ntt_ctrl_pkg::ISSUE_TOTAL);
    endfunction

    function automatic int drain_cycles(input int it);
        case (it)
            0: return int'(ntt_ctrl_pkg::DRAIN0_BOUND) + 1;
            1: return int'(ntt_ctrl_pkg::DRAIN1_BOUND) + 1;
            2: return int'(ntt_ctrl_pkg::DRAIN2_BOUND) + 1;
            default: return int'(ntt_ctrl_pkg::DRAIN3_BOUND) + 1;
        endcase
    endfunction

    // ite2 walks base, base+1, base+1, base per issue
    function automatic logic [ntt_ctrl_pkg::DEPTH_W-1:0] expected_depth(input int it,
                                                                         input int idx);
        logic [ntt_ctrl_pkg::DEPTH_W-1:0] base;
        base = ntt_ctrl_pkg::ITE2_BASE_DEPTH;
        case (it)
            0: return '0;
            1: return ntt_ctrl_pkg::DEPTH_W'(1);
            2: return ((idx % 4 == 1) || (idx % 4 == 2))
                      ? base + ntt_ctrl_pkg::DEPTH_W'(1) : base;
            default: return ntt_ctrl_pkg::LAST_L;
        endcase
    endfunction

    task automatic define_row(input int idx, input string name, input int bn_pct,
                              input int ren_pct, input int done_pct);
        row_name[idx]     = name;
        row_bn_pct[idx]   = bn_pct;
        row_ren_pct[idx]  = ren_pct;
        row_done_pct[idx] = done_pct;
        row_issues[idx]   = ISSUES_PER_RUN;
        row_drain_w[idx]  = DRAIN_WRITES;
    endtask

    task automatic report_mismatch(input string test, input string sig, input int expected,
                                   input int actual);
        $display("Fail %s %s expected %0d actual %0d at %0t", test, sig, expected, actual, $time);
        errors++;
    endtask

    task automatic advance_model(input logic issued, input logic hold_reset);
        logic init_was_done;
        init_was_done = (m_init > int'(ntt_ctrl_pkg::DEGREE));
        if (hold_reset) begin
            m_ph   = M_RESET;
            m_init = 0;
        end else begin
            if (!init_was_done) begin
                m_init++;
            end
            case (m_ph)
                M_RESET: m_ph = M_IDLE;
                M_IDLE: begin
                    if (init_was_done) begin
                        m_ph  = M_ITE;
                        m_it  = 0;
                        m_cnt = 0;
                        m_phc = 0;
                    end
                end
                M_ITE: begin
                    m_phc++;
                    if (issued) begin
                        m_cnt++;
                    end
                    if (m_cnt == issue_target(m_it)) begin
                        m_ph  = M_DRAIN;
                        m_cnt = 0;
                    end
                end
                M_DRAIN: begin
                    m_cnt++;
                    if (m_cnt == drain_cycles(m_it)) begin
                        m_ph  = (m_it == 3) ? M_FINISH : M_ITE;
                        m_it  = (m_it == 3) ? m_it : m_it + 1;
                        m_cnt = 0;
                        m_phc = 0;
                    end
                end
                default: m_ph = M_IDLE;
            endcase
        end
    endtask

    // drive on the falling edge, compare a quarter period later
    task automatic step_cycle(input int row, input logic hold_reset);
        logic                             exp_issue;
        logic [ntt_ctrl_pkg::DEPTH_W-1:0] exp_depth;
        logic                             exp_agu;
        logic                             exp_w;
        logic                             exp_busy;
        string                            test;
        @(negedge clk);
        rst          = hold_reset;
        bn_ma_out_en = chance(row_bn_pct[row]);
        r_enable_out = chance(row_ren_pct[row]);
        // results stay quiet during drains
        if ((m_ph != M_DRAIN) && chance(row_done_pct[row])) begin
            ntt_done = 2'(32'd1 + next_random() % 32'd3);
        end else begin
            ntt_done = 2'b00;
        end
        #2;
        test      = row_name[row];
        exp_busy  = (m_ph == M_ITE) || (m_ph == M_DRAIN);
        exp_issue = (m_ph == M_ITE) && bn_ma_out_en;
        exp_depth = exp_issue ? expected_depth(m_it, m_cnt) : '0;
        exp_agu   = (m_ph == M_ITE) && ((m_it == 0) ?
                    (m_phc < int'(ntt_ctrl_pkg::AGU_ITE0_CYCLES)) : (m_it != 3));
        exp_w     = (m_ph == M_DRAIN) || ((m_ph == M_ITE) && (ntt_done != 2'b00));
        if (tf_init_base !== (m_ph == M_IDLE)) report_mismatch(test, "tf_init_base",
            int'(m_ph == M_IDLE), int'(tf_init_base));
        if (tf_ren !== exp_issue) report_mismatch(test, "tf_ren", int'(exp_issue), int'(tf_ren));
        if (r_enable !== exp_issue) report_mismatch(test, "r_enable", int'(exp_issue),
            int'(r_enable));
        if (it_depth_cnt !== exp_depth) report_mismatch(test, "it_depth_cnt", int'(exp_depth),
            int'(it_depth_cnt));
        if (agu_enable !== exp_agu) report_mismatch(test, "agu_enable", int'(exp_agu),
            int'(agu_enable));
        if (agu_enable_k2 !== ((m_ph == M_ITE) && (m_it == 3))) report_mismatch(test,
            "agu_enable_k2", int'((m_ph == M_ITE) && (m_it == 3)), int'(agu_enable_k2));
        if (w_enable !== exp_w) report_mismatch(test, "w_enable", int'(exp_w), int'(w_enable));
        if (last_stage !== (exp_busy && (m_it == 3))) report_mismatch(test, "last_stage",
            int'(exp_busy && (m_it == 3)), int'(last_stage));
        if (ntt_enable !== (exp_busy && r_enable_out)) report_mismatch(test, "ntt_enable",
            int'(exp_busy && r_enable_out), int'(ntt_enable));
        if (done !== (m_ph == M_FINISH)) report_mismatch(test, "done", int'(m_ph == M_FINISH),
            int'(done));
        cycles++;
        n_ren     += int'(r_enable === 1'b1);
        n_ren_tf  += int'((r_enable === 1'b1) && (tf_ren === 1'b1));
        n_wdrain  += int'((w_enable === 1'b1) && (ntt_done == 2'b00));
        n_base    += int'(tf_init_base === 1'b1);
        seen_done  = (done === 1'b1);
        advance_model(exp_issue, hold_reset);
    endtask

    initial begin
        int   cyc;
        logic timed_out;
        int   assert_fails;
        rst          = 1'b1;
        bn_ma_out_en = 1'b0;
        r_enable_out = 1'b0;
        ntt_done     = 2'b00;
        lcg_state    = 32'h6e2a;
        errors       = 0;
        cycles       = 0;
        m_ph         = M_RESET;
        m_it         = 0;
        m_cnt        = 0;
        m_phc        = 0;
        m_init       = 0;
        timed_out    = 1'b0;
        define_row(0, "full_rate", 100, 100, 100);
        define_row(1, "half_rate", 50, 50, 50);
        define_row(2, "sparse_issue", 15, 30, 10);
        define_row(3, "no_results", 70, 0, 0);
        define_row(4, "bursty", 85, 90, 95);

        for (int i = 0; i < 10; i++) begin
            step_cycle(0, 1'b1);
        end

        for (int row = 0; row < NUM_ROWS && !timed_out; row++) begin
            n_ren     = 0;
            n_ren_tf  = 0;
            n_wdrain  = 0;
            n_base    = 0;
            seen_done = 1'b0;
            cyc       = 0;
            while (!seen_done && cyc < TIMEOUT_CYCLES) begin
                step_cycle(row, 1'b0);
                cyc++;
            end
            if (!seen_done) begin
                $display("Error: %s never raised done within %0d cycles", row_name[row], cyc);
                errors++;
                timed_out = 1'b1;
            end else begin
                if (n_ren != row_issues[row]) report_mismatch(row_name[row], "read_issues",
                    row_issues[row], n_ren);
                if (n_ren_tf != row_issues[row]) report_mismatch(row_name[row], "twiddle_reads",
                    row_issues[row], n_ren_tf);
                if (n_wdrain != row_drain_w[row]) report_mismatch(row_name[row], "drain_writes",
                    row_drain_w[row], n_wdrain);
                // only the first idle waits for the init time
                if (n_base != ((row == 0) ? int'(ntt_ctrl_pkg::DEGREE) + 1 : 1)) begin
                    report_mismatch(row_name[row], "init_base_cycles",
                        (row == 0) ? int'(ntt_ctrl_pkg::DEGREE) + 1 : 1, n_base);
                end
            end
        end

        // done must drop again and the next transform start cleanly
        if (!timed_out) begin
            for (int i = 0; i < 3; i++) begin
                step_cycle(NUM_ROWS - 1, 1'b0);
            end
        end

        assert_fails = ntt_ctrl_top_inst.ntt_ctrl_assertions_inst.failures;
        $display("cycles %0d, check errors %0d, assertion failures %0d",
                 cycles, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/ntt_ctrl_pkg.sv
source/ntt_phase_fsm.sv
source/ntt_phase_counters.sv
source/ntt_ctrl_outputs.sv
source/ntt_ctrl_top.sv
tests/ntt_ctrl_assertions.sv
tests/ntt_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ntt_ctrl_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
